/* Makefile */
# Verilator build and run for the modular exponentiation engine
TOP = modexp_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f modexp.f --top-module $(TOP) -Mdir obj_dir

# The log decides pass or fail, the simulator status is not used
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/exp_sequencer.sv */
// Right-to-left square-and-multiply control around the shared multiplier
// Takes one job from the request slot and reports it to the result stage
`timescale 1ns/1ps
`default_nettype none
`include "modexp_settings.svh"

module exp_sequencer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire modexp_pkg::exp_job_t   job,
    input  wire                         job_valid,
    input  wire modexp_pkg::operand_t   mul_product,
    input  wire                         mul_done,
    output logic                        job_take,
    output logic                        mul_go,
    output modexp_pkg::operand_t        mul_a,
    output modexp_pkg::operand_t        mul_b,
    output modexp_pkg::operand_t        mul_mod,
    output modexp_pkg::exp_result_t     fin,
    output logic                        fin_valid,
    output logic                        seq_active
);

    modexp_pkg::seq_state_e         state;
    modexp_pkg::operand_t           mod_r;
    modexp_pkg::operand_t           base_r;
    modexp_pkg::operand_t           acc_r;
    logic [`MODEXP_EXP_WIDTH-1:0]   exp_r;
    logic                           err_r;

    assign job_take   = (state == modexp_pkg::seq_idle) && job_valid;
    assign seq_active = (state != modexp_pkg::seq_idle);
    assign fin_valid  = (state == modexp_pkg::seq_finish);
    assign fin.value  = acc_r;
    assign fin.error  = err_r;
    assign mul_mod    = mod_r;

    // Operand select per multiplication kind
    always_comb begin
        case (state)
            modexp_pkg::seq_reduce: begin
                // message * 1 mod m brings the base below m
                mul_a = base_r;
                mul_b = modexp_pkg::operand_t'(1);
            end
            modexp_pkg::seq_multiply: begin
                mul_a = acc_r;
                mul_b = base_r;
            end
            default: begin
                mul_a = base_r;
                mul_b = base_r;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= modexp_pkg::seq_idle;
            mul_go <= 1'b0;
        end else begin
            mul_go <= 1'b0;
            case (state)
                modexp_pkg::seq_idle: begin
                    if (job_valid) begin
                        if (job.invalid) begin
                            state <= modexp_pkg::seq_finish;
                        end else begin
                            state  <= modexp_pkg::seq_reduce;
                            mul_go <= 1'b1;
                        end
                    end
                end
                modexp_pkg::seq_reduce: begin
                    if (mul_done) begin
                        state <= modexp_pkg::seq_step;
                    end
                end
                modexp_pkg::seq_step: begin
                    if (exp_r == '0) begin
                        state <= modexp_pkg::seq_finish;
                    end else if (exp_r[0]) begin
                        state  <= modexp_pkg::seq_multiply;
                        mul_go <= 1'b1;
                    end else begin
                        state  <= modexp_pkg::seq_square;
                        mul_go <= 1'b1;
                    end
                end
                modexp_pkg::seq_multiply: begin
                    // Square always follows a multiply
                    if (mul_done) begin
                        state  <= modexp_pkg::seq_square;
                        mul_go <= 1'b1;
                    end
                end
                modexp_pkg::seq_square: begin
                    if (mul_done) begin
                        state <= modexp_pkg::seq_step;
                    end
                end
                default: begin
                    state <= modexp_pkg::seq_idle;
                end
            endcase
        end
    end

    // Job registers and running values
    always_ff @(posedge clk) begin
        if (job_take) begin
            mod_r  <= job.modulus;
            base_r <= job.message;
            exp_r  <= job.exponent;
            err_r  <= job.invalid;
            // 1 mod m is 1 for any legal modulus, invalid jobs report 0
            acc_r  <= job.invalid ? '0 : modexp_pkg::operand_t'(1);
        end else if (mul_done) begin
            case (state)
                modexp_pkg::seq_reduce:   base_r <= mul_product;
                modexp_pkg::seq_multiply: acc_r  <= mul_product;
                modexp_pkg::seq_square: begin
                    base_r <= mul_product;
                    exp_r  <= exp_r >> 1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/modexp_pkg.sv */
// Types passed between the request, exponentiation and result stages
// Referenced with scoped names from each stage
`default_nettype none
`include "modexp_settings.svh"

package modexp_pkg;

    // Message, modulus and result values
    typedef logic [`MODEXP_MOD_WIDTH-1:0] operand_t;

    // One pending job as held by the request slot
    typedef struct packed {
        operand_t                     message;
        operand_t                     modulus;
        logic [`MODEXP_EXP_WIDTH-1:0] exponent;
        logic                         invalid;
    } exp_job_t;

    // Finished job handed to the result stage
    typedef struct packed {
        operand_t value;
        logic     error;
    } exp_result_t;

    // Square-and-multiply sequencer states
    typedef enum logic [2:0] {
        seq_idle,
        seq_reduce,
        seq_multiply,
        seq_square,
        seq_step,
        seq_finish
    } seq_state_e;

endpackage

`default_nettype wire

/* design/modexp_settings.svh */
// Operand widths and the legality rule for the modular exponentiation engine
// Included by the package and by any RTL file that sizes ports from these values
`ifndef MODEXP_SETTINGS_SVH
`define MODEXP_SETTINGS_SVH

// Width of message, modulus and result
`define MODEXP_MOD_WIDTH 16

// Width of the exponent
`define MODEXP_EXP_WIDTH 4

// Smallest modulus that is computed rather than flagged
`define MODEXP_MIN_MODULUS 2

`endif

/* design/modexp_top.sv */
// Modular exponentiation engine: request slot, sequencer, multiplier, result register
// Drive start with the operands for one cycle; done pulses with result and error
`timescale 1ns/1ps
`default_nettype none
`include "modexp_settings.svh"

module modexp_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           start,
    input  wire modexp_pkg::operand_t     message,
    input  wire modexp_pkg::operand_t     modulus,
    input  wire [`MODEXP_EXP_WIDTH-1:0]   exponent,
    output wire                           busy,
    output wire                           done,
    output modexp_pkg::operand_t          result,
    output wire                           error
);

    modexp_pkg::exp_job_t    job;
    logic                    job_valid;
    logic                    job_take;
    logic                    mul_go;
    modexp_pkg::operand_t    mul_a;
    modexp_pkg::operand_t    mul_b;
    modexp_pkg::operand_t    mul_mod;
    modexp_pkg::operand_t    mul_product;
    logic                    mul_done;
    modexp_pkg::exp_result_t fin;
    logic                    fin_valid;
    logic                    seq_active;

    // Full slot or a job in progress
    assign busy = job_valid || seq_active;

    request_stage u_request (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .message   (message),
        .modulus   (modulus),
        .exponent  (exponent),
        .job_take  (job_take),
        .job       (job),
        .job_valid (job_valid)
    );

    exp_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .job         (job),
        .job_valid   (job_valid),
        .mul_product (mul_product),
        .mul_done    (mul_done),
        .job_take    (job_take),
        .mul_go      (mul_go),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_mod     (mul_mod),
        .fin         (fin),
        .fin_valid   (fin_valid),
        .seq_active  (seq_active)
    );

    modmul_unit u_modmul (
        .clk         (clk),
        .rst         (rst),
        .mul_go      (mul_go),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_mod     (mul_mod),
        .mul_product (mul_product),
        .mul_done    (mul_done)
    );

    result_stage u_result (
        .clk       (clk),
        .rst       (rst),
        .fin       (fin),
        .fin_valid (fin_valid),
        .done      (done),
        .result    (result),
        .error     (error)
    );

endmodule

`default_nettype wire

/* design/modmul_unit.sv */
// Interleaved shift-add modular multiplier, one bit of mul_a per cycle
// Pulse mul_go with stable operands below mul_mod; mul_done follows W+1 cycles later
`timescale 1ns/1ps
`default_nettype none
`include "modexp_settings.svh"

module modmul_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       mul_go,
    input  wire modexp_pkg::operand_t mul_a,
    input  wire modexp_pkg::operand_t mul_b,
    input  wire modexp_pkg::operand_t mul_mod,
    output modexp_pkg::operand_t      mul_product,
    output logic                      mul_done
);

    localparam int W  = `MODEXP_MOD_WIDTH;
    localparam int CW = $clog2(W);

    logic                 running;
    logic [CW-1:0]        bit_cnt;
    modexp_pkg::operand_t a_q;
    modexp_pkg::operand_t b_q;
    modexp_pkg::operand_t m_q;

    // Extra top bit absorbs the carry of doubling and of adding b
    logic [W:0] acc_q;
    logic [W:0] dbl;
    logic [W:0] dbl_red;
    logic [W:0] sum;
    logic [W:0] sum_red;
    logic [W:0] acc_next;

    // acc < m on entry, so each step needs at most one subtraction
    always_comb begin
        dbl      = acc_q + acc_q;
        dbl_red  = (dbl >= {1'b0, m_q}) ? dbl - {1'b0, m_q} : dbl;
        sum      = dbl_red + {1'b0, b_q};
        sum_red  = (sum >= {1'b0, m_q}) ? sum - {1'b0, m_q} : sum;
        acc_next = a_q[W-1] ? sum_red : dbl_red;
    end

    assign mul_product = acc_q[W-1:0];

    // Control: W processing cycles after the go cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running  <= 1'b0;
            bit_cnt  <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_go) begin
                running <= 1'b1;
                bit_cnt <= CW'(W - 1);
            end else if (running) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == '0) begin
                    running  <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // Datapath, scanning a from its MSB
    always_ff @(posedge clk) begin
        if (mul_go) begin
            a_q   <= mul_a;
            b_q   <= mul_b;
            m_q   <= mul_mod;
            acc_q <= '0;
        end else if (running) begin
            a_q   <= a_q << 1;
            acc_q <= acc_next;
        end
    end

    // Only one multiplication in flight
    assert property (@(posedge clk) disable iff (rst) mul_go |-> !running)
        else $error("modmul_unit: mul_go while a multiplication is running");

    // Operands from the sequencer must already be reduced
    assert property (@(posedge clk) disable iff (rst)
                     mul_go |-> (mul_a < mul_mod || mul_b == 1) && mul_b < mul_mod)
        else $error("modmul_unit: operand not below the modulus");

endmodule

`default_nettype wire

/* design/request_stage.sv */
// One-entry job slot in front of the sequencer
// Accepts a start only when empty and flags an illegal modulus on capture
`timescale 1ns/1ps
`default_nettype none
`include "modexp_settings.svh"

module request_stage (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               start,
    input  wire modexp_pkg::operand_t         message,
    input  wire modexp_pkg::operand_t         modulus,
    input  wire [`MODEXP_EXP_WIDTH-1:0]       exponent,
    input  wire                               job_take,
    output modexp_pkg::exp_job_t              job,
    output logic                              job_valid
);

    logic accept;
    logic mod_too_small;

    // Starts arriving while the slot is full are dropped
    assign accept = start && !job_valid;

    assign mod_too_small = (modulus < modexp_pkg::operand_t'(`MODEXP_MIN_MODULUS));

    // Slot occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job_valid <= 1'b0;
        end else if (job_take) begin
            job_valid <= 1'b0;
        end else if (accept) begin
            job_valid <= 1'b1;
        end
    end

    // Job contents, only meaningful while job_valid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            job.message  <= message;
            job.modulus  <= modulus;
            job.exponent <= exponent;
            job.invalid  <= mod_too_small;
        end
    end

    // Sequencer may only take a job that is actually there
    assert property (@(posedge clk) disable iff (rst) job_take |-> job_valid)
        else $error("request_stage: job_take without a pending job");

endmodule

`default_nettype wire

/* design/result_stage.sv */
// Output register for finished jobs
// Holds result and error between completions and pulses done once per job
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire                           clk,
    input  wire                           rst,
    input  wire modexp_pkg::exp_result_t  fin,
    input  wire                           fin_valid,
    output logic                          done,
    output modexp_pkg::operand_t          result,
    output logic                          error
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
            error  <= 1'b0;
        end else begin
            done <= fin_valid;
            if (fin_valid) begin
                result <= fin.value;
                error  <= fin.error;
            end
        end
    end

    // Sequencer leaves finish after one cycle, so done is always a single pulse
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("result_stage: done held for more than one cycle");

    // Error results carry a zero value
    assert property (@(posedge clk) disable iff (rst) done && error |-> result == '0)
        else $error("result_stage: error reported with a nonzero result");

endmodule

`default_nettype wire

/* modexp.f */
+incdir+design
+incdir+test
design/modexp_pkg.sv
design/request_stage.sv
design/modmul_unit.sv
design/exp_sequencer.sv
design/result_stage.sv
design/modexp_top.sv
test/modexp_tb.sv

/* test/modexp_ref.svh */
// Reference model for the modular exponentiation engine
// Included inside the testbench module to derive expected result and error
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

// A modulus below the minimum is reported, not computed
function automatic logic modulus_illegal(input modexp_pkg::operand_t modulus);
    return modulus < modexp_pkg::operand_t'(`MODEXP_MIN_MODULUS);
endfunction

// Plain repeated multiplication, exponent times
function automatic modexp_pkg::operand_t mod_power(
    input modexp_pkg::operand_t         message,
    input modexp_pkg::operand_t         modulus,
    input logic [`MODEXP_EXP_WIDTH-1:0] exponent
);
    logic [31:0] m;
    logic [31:0] base;
    logic [31:0] acc;
    m = 32'(modulus);
    if (modulus_illegal(modulus)) begin
        return '0;
    end
    base = 32'(message) % m;
    acc  = 32'd1 % m;
    for (int i = 0; i < int'(exponent); i++) begin
        // Both factors are below 2^16, so the product fits in 32 bits
        acc = (acc * base) % m;
    end
    return acc[`MODEXP_MOD_WIDTH-1:0];
endfunction

`endif

/* test/modexp_tb.sv */
// Table-driven testbench for modexp_top
// Runs directed, queued, dropped and random jobs against the reference model
`timescale 1ns/1ps
`default_nettype none
`include "modexp_settings.svh"

module modexp_tb;

    localparam int done_timeout = 400;

    // One table row with its expected response
    typedef struct packed {
        modexp_pkg::operand_t         message;
        modexp_pkg::operand_t         modulus;
        logic [`MODEXP_EXP_WIDTH-1:0] exponent;
        modexp_pkg::operand_t         exp_value;
        logic                         exp_error;
    } row_t;

    logic                         clk;
    logic                         rst;
    logic                         start;
    modexp_pkg::operand_t         message;
    modexp_pkg::operand_t         modulus;
    logic [`MODEXP_EXP_WIDTH-1:0] exponent;
    wire                          busy;
    wire                          done;
    modexp_pkg::operand_t         result;
    wire                          error;

    row_t rows[$];
    int   accepted;
    int   done_count;
    logic done_prev;

    `include "modexp_ref.svh"

    modexp_top UUT (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .message  (message),
        .modulus  (modulus),
        .exponent (exponent),
        .busy     (busy),
        .done     (done),
        .result   (result),
        .error    (error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_result(input string name, input modexp_pkg::operand_t got,
                                  input modexp_pkg::operand_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                        $time, name, got, expected));
        end
    endtask

    task automatic compare_error(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                        $time, name, got, expected));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                        $time, name, got, expected));
        end
    endtask

    function automatic row_t make_row(input modexp_pkg::operand_t m,
                                      input modexp_pkg::operand_t n,
                                      input logic [`MODEXP_EXP_WIDTH-1:0] e);
        row_t r;
        r.message   = m;
        r.modulus   = n;
        r.exponent  = e;
        r.exp_value = mod_power(m, n, e);
        r.exp_error = modulus_illegal(n);
        return r;
    endfunction

    task automatic add_row(input modexp_pkg::operand_t m, input modexp_pkg::operand_t n,
                           input logic [`MODEXP_EXP_WIDTH-1:0] e);
        rows.push_back(make_row(m, n, e));
    endtask

    // One-cycle start strobe, sampled on the second rising edge
    task automatic issue_start(input row_t r);
        @(posedge clk);
        #1;
        start    = 1'b1;
        message  = r.message;
        modulus  = r.modulus;
        exponent = r.exponent;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > done_timeout) begin
                stop_with_failure("timed out waiting for done");
            end
        end while (!done);
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) begin
                stop_with_failure("busy did not rise after a start");
            end
        end while (!busy);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > done_timeout) begin
                stop_with_failure("timed out waiting for busy to fall");
            end
        end while (busy);
    endtask

    task automatic run_row(input row_t r);
        wait_idle();
        issue_start(r);
        accepted++;
        wait_done();
        compare_result("result", result, r.exp_value);
        compare_error("error", error, r.exp_error);
    endtask

    // Count done pulses and catch any pulse longer than one cycle
    always @(negedge clk) begin
        if (rst) begin
            done_prev  = 1'b0;
            done_count = 0;
        end else if (done && done_prev) begin
            stop_with_failure("done stayed high for two cycles");
        end else begin
            if (done) begin
                done_count++;
            end
            done_prev = done;
        end
    end

    initial begin
        row_t        job_a;
        row_t        job_b;
        row_t        job_c;
        logic [31:0] rnd_m;
        logic [31:0] rnd_n;
        logic [31:0] rnd_e;
        void'($urandom(32'h5966_99ed));
        rst        = 1'b1;
        start      = 1'b0;
        message    = '0;
        modulus    = '0;
        exponent   = '0;
        accepted   = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        compare_flag("busy", busy, 1'b0);
        compare_flag("done", done, 1'b0);
        compare_error("error", error, 1'b0);
        compare_result("result", result, '0);

        // Directed and edge rows, invalid moduli each followed by a valid job
        add_row(16'd4, 16'd497, 4'd13);
        add_row(16'd7, 16'd10, 4'd2);
        add_row(16'd3, 16'd7, 4'd0);
        add_row(16'd12345, 16'd2, 4'd0);
        add_row(16'd100, 16'd7, 4'd3);
        add_row(16'd7, 16'd7, 4'd5);
        add_row(16'hfffe, 16'hffff, 4'd15);
        add_row(16'h1234, 16'hffff, 4'd11);
        add_row(16'd5, 16'd0, 4'd3);
        add_row(16'd9, 16'd11, 4'd7);
        add_row(16'd5, 16'd1, 4'd0);
        add_row(16'd2, 16'd3, 4'd15);
        add_row(16'd0, 16'd13, 4'd0);
        add_row(16'd0, 16'd13, 4'd5);
        for (int i = 0; i < 24; i++) begin
            rnd_m = $urandom;
            rnd_n = $urandom;
            rnd_e = $urandom;
            add_row(rnd_m[`MODEXP_MOD_WIDTH-1:0], rnd_n[`MODEXP_MOD_WIDTH-1:0],
                    rnd_e[`MODEXP_EXP_WIDTH-1:0]);
        end
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end

        // B queues behind A, C arrives with the slot full and is dropped
        job_a = make_row(16'h0bad, 16'hfff1, 4'd15);
        job_b = make_row(16'd3, 16'd1000, 4'd13);
        job_c = make_row(16'd2, 16'd5, 4'd3);
        wait_idle();
        issue_start(job_a);
        accepted++;
        wait_busy();
        issue_start(job_b);
        accepted++;
        wait_busy();
        issue_start(job_c);
        wait_done();
        compare_result("result", result, job_a.exp_value);
        compare_error("error", error, job_a.exp_error);
        wait_done();
        compare_result("result", result, job_b.exp_value);
        compare_error("error", error, job_b.exp_error);
        wait_idle();
        repeat (20) @(negedge clk);

        if (done_count != accepted) begin
            $display("%0d done pulses for %0d accepted starts", done_count, accepted);
            $display("Checks failed");
            $fatal(1, "done count differs from accepted starts");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
